/* common/exu_pkg.sv */
package exu_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 20;
    localparam int FUNC_W     = 32;

    localparam logic [DATA_W-1:0] PC_LAG = 32'd8; // fetch runs two insts ahead

    localparam int SET_RVI_BIT = 0;
    localparam int SET_RVM_BIT = 1;

    // opcode bits, rvi view
    localparam int OP_ADD   = 23;
    localparam int OP_SUB   = 22;
    localparam int OP_SLL   = 21;
    localparam int OP_SRL   = 20;
    localparam int OP_SRA   = 19;
    localparam int OP_OR    = 18;
    localparam int OP_AND   = 17;
    localparam int OP_XOR   = 16;
    localparam int OP_SLT   = 15;
    localparam int OP_LOAD  = 14;
    localparam int OP_STORE = 13;
    localparam int OP_FENCE = 12;
    localparam int OP_B     = 11;
    localparam int OP_JAL   = 10;
    localparam int OP_JALR  = 9;
    localparam int OP_AUIPC = 8;
    localparam int OP_LUI   = 7;
    localparam int OP_ECALL = 6;
    localparam int OP_EBREA = 5;
    localparam int OP_MRET  = 4;
    localparam int OP_WFI   = 3;
    localparam int OP_CSRRW = 2;
    localparam int OP_CSRRS = 1;
    localparam int OP_CSRRC = 0;

    // opcode bits, rvm view
    localparam int OP_MUL = 23;
    localparam int OP_DIV = 22;
    localparam int OP_REM = 21;

    typedef struct packed {
        logic        unsign;
        logic        imm;
        logic [1:0]  spare;
        logic        eq;
        logic        ne;
        logic        lt;
        logic        ge;
        logic [23:0] op;
    } exu_rvi_t;

    typedef struct packed {
        logic        unsign;
        logic        high;
        logic        op2_unsign;
        logic        op1_unsign;
        logic [3:0]  unused;
        logic [23:0] op;
    } exu_rvm_t;

    typedef union packed {
        exu_rvi_t rvi;
        exu_rvm_t rvm;
    } exu_func_u;

endpackage

/* dv/exu_tb.sv */
`timescale 1ns/10ps

module exu_tb;

    localparam int W             = exu_pkg::DATA_W;
    localparam int DRIVE_DLY     = 2;
    localparam int SAMPLE_DLY    = 5;
    localparam int RESET_TIMEOUT = 20;
    localparam int DIV_TIMEOUT   = 2 * exu_pkg::DATA_W + 8;
    localparam logic [1:0] SET_RVI = 2'(1 << exu_pkg::SET_RVI_BIT);
    localparam logic [1:0] SET_RVM = 2'(1 << exu_pkg::SET_RVM_BIT);

    logic                           clk;
    logic                           reset;
    logic [1:0]                     inst_set;
    exu_pkg::exu_func_u             inst_func;
    logic [W-1:0]                   pc;
    logic [W-1:0]                   reg1_rdata;
    logic [W-1:0]                   reg2_rdata;
    logic [exu_pkg::IMM_W-1:0]      uimm;
    logic [exu_pkg::REG_ADDR_W-1:0] reg_waddr;
    logic                           reg_waddr_vld;
    logic                           hold_flag;
    logic                           jump_flag;
    logic [W-1:0]                   jump_addr;
    logic [exu_pkg::REG_ADDR_W-1:0] reg_waddr_out;
    logic                           reg_waddr_vld_out;
    logic [W-1:0]                   result;
    logic                           result_vld;

    tb_clk_gen i_clk_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    exu i_exu (
        .clk_i           (clk),
        .reset_i         (reset),
        .inst_set_i      (inst_set),
        .inst_func_i     (inst_func),
        .pc_i            (pc),
        .reg1_rdata_i    (reg1_rdata),
        .reg2_rdata_i    (reg2_rdata),
        .uimm_i          (uimm),
        .reg_waddr_i     (reg_waddr),
        .reg_waddr_vld_i (reg_waddr_vld),
        .hold_flag_o     (hold_flag),
        .jump_flag_o     (jump_flag),
        .jump_addr_o     (jump_addr),
        .reg_waddr_o     (reg_waddr_out),
        .reg_waddr_vld_o (reg_waddr_vld_out),
        .result_o        (result),
        .result_vld_o    (result_vld)
    );

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(input string name, input logic [W-1:0] actual,
                           input logic [W-1:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic clear_inputs();
        inst_set      = '0;
        inst_func     = '0;
        pc            = '0;
        reg1_rdata    = '0;
        reg2_rdata    = '0;
        uimm          = '0;
        reg_waddr     = '0;
        reg_waddr_vld = 1'b0;
    endtask

    // drives one op with a fresh pc and register address, then waits to sample
    task automatic drive_op(input logic [1:0] set, input exu_pkg::exu_func_u func,
                            input logic [W-1:0] a, input logic [W-1:0] b,
                            input logic [exu_pkg::IMM_W-1:0] imm, input logic waddr_vld);
        next_cycle();
        inst_set      = set;
        inst_func     = func;
        reg1_rdata    = a;
        reg2_rdata    = b;
        uimm          = imm;
        pc            = $urandom() & ~32'h3;
        reg_waddr     = 5'($urandom());
        reg_waddr_vld = waddr_vld;
        #SAMPLE_DLY;
    endtask

    task automatic check_result(input logic [W-1:0] expected, input logic jump_exp);
        compare("result_o", result, expected);
        compare("result_vld_o", result_vld, 1'b1);
        compare("reg_waddr_o", reg_waddr_out, reg_waddr);
        compare("reg_waddr_vld_o", reg_waddr_vld_out, reg_waddr_vld);
        compare("hold_flag_o", hold_flag, 1'b0);
        compare("jump_flag_o", jump_flag, jump_exp);
    endtask

    function automatic logic [W-1:0] alu_ref(input int op, input logic uns, input logic use_imm,
                                             input logic [W-1:0] a, input logic [W-1:0] b_reg,
                                             input logic [exu_pkg::IMM_W-1:0] imm);
        logic [W-1:0] b;
        logic [W-1:0] res;
        if (!use_imm) begin
            b = b_reg;
        end else if (op == exu_pkg::OP_SLT || !uns) begin
            b = {{20{imm[11]}}, imm[11:0]};
        end else begin
            b = {20'b0, imm[11:0]};
        end
        case (op)
            exu_pkg::OP_ADD: res = a + b;
            exu_pkg::OP_SUB: res = a - b;
            exu_pkg::OP_SLL: res = a << b[4:0];
            exu_pkg::OP_SRL: res = a >> b[4:0];
            exu_pkg::OP_SRA: res = $signed(a) >>> b[4:0];
            exu_pkg::OP_OR:  res = a | b;
            exu_pkg::OP_AND: res = a & b;
            exu_pkg::OP_XOR: res = a ^ b;
            exu_pkg::OP_SLT: res = uns ? {31'b0, a < b} : {31'b0, $signed(a) < $signed(b)};
            default:         res = '0;
        endcase
        return res;
    endfunction

    function automatic logic [W-1:0] divide_ref(input logic is_rem, input logic uns,
                                                input logic [W-1:0] a, input logic [W-1:0] b);
        longint sa;
        longint sb;
        longint res;
        if (b == '0) begin
            return is_rem ? a : '1;
        end
        sa  = uns ? {32'b0, a} : {{32{a[31]}}, a};
        sb  = uns ? {32'b0, b} : {{32{b[31]}}, b};
        res = is_rem ? sa % sb : sa / sb;   // 64 bits, so min / -1 cannot overflow
        return res[W-1:0];
    endfunction

    task automatic test_reset();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0) begin
            if (cycles == RESET_TIMEOUT) begin
                $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
                abort_run();
            end
            @(posedge clk);
            cycles++;
        end
        next_cycle();
        #SAMPLE_DLY;
        compare("hold_flag_o", hold_flag, 1'b0);
        compare("jump_flag_o", jump_flag, 1'b0);
        compare("result_vld_o", result_vld, 1'b0);
    endtask

    task automatic test_alu();
        int ops [9] = '{exu_pkg::OP_ADD, exu_pkg::OP_SUB, exu_pkg::OP_SLL, exu_pkg::OP_SRL,
                        exu_pkg::OP_SRA, exu_pkg::OP_OR, exu_pkg::OP_AND, exu_pkg::OP_XOR,
                        exu_pkg::OP_SLT};
        exu_pkg::exu_func_u        f;
        logic [W-1:0]              a;
        logic [W-1:0]              b;
        logic [exu_pkg::IMM_W-1:0] imm;
        foreach (ops[i]) begin
            for (int form = 0; form < 4; form++) begin  // imm flag, unsigned flag
                repeat (4) begin
                    a   = $urandom();
                    b   = $urandom();
                    imm = 20'($urandom());
                    f   = '0;
                    f.rvi.op[ops[i]] = 1'b1;
                    f.rvi.imm        = form[0];
                    f.rvi.unsign     = form[1];
                    drive_op(SET_RVI, f, a, b, imm, 1'b1);
                    check_result(alu_ref(ops[i], form[1], form[0], a, b, imm), 1'b0);
                end
            end
        end
        repeat (8) begin
            imm = 20'($urandom());
            f   = '0;
            f.rvi.op[exu_pkg::OP_LUI] = 1'b1;
            drive_op(SET_RVI, f, $urandom(), $urandom(), imm, 1'b1);
            check_result({imm, 12'b0}, 1'b0);
            f = '0;
            f.rvi.op[exu_pkg::OP_AUIPC] = 1'b1;
            drive_op(SET_RVI, f, $urandom(), $urandom(), imm, 1'b1);
            check_result(pc - exu_pkg::PC_LAG + {imm, 12'b0}, 1'b0);
        end
    endtask

    // cond 0..3 selects eq, ne, lt, ge
    task automatic run_branch(input int cond, input logic uns, input logic [W-1:0] a,
                              input logic [W-1:0] b);
        exu_pkg::exu_func_u        f;
        logic [exu_pkg::IMM_W-1:0] imm;
        logic                      lt;
        logic                      taken;
        imm = 20'($urandom());
        f   = '0;
        f.rvi.op[exu_pkg::OP_B] = 1'b1;
        f.rvi.unsign = uns;
        {f.rvi.eq, f.rvi.ne, f.rvi.lt, f.rvi.ge} = 4'b1000 >> cond;
        lt = uns ? (a < b) : ($signed(a) < $signed(b));
        case (cond)
            0:       taken = (a == b);
            1:       taken = (a != b);
            2:       taken = lt;
            default: taken = !lt;
        endcase
        drive_op(SET_RVI, f, a, b, imm, 1'b0);
        check_result('0, taken);
        if (taken) begin
            compare("jump_addr_o", jump_addr,
                    pc - exu_pkg::PC_LAG + {{19{imm[11]}}, imm[11:0], 1'b0});
        end
    endtask

    task automatic test_branch();
        exu_pkg::exu_func_u        f;
        logic [W-1:0]              a;
        logic [exu_pkg::IMM_W-1:0] imm;
        for (int cond = 0; cond < 4; cond++) begin
            for (int u = 0; u < 2; u++) begin
                a = $urandom();
                run_branch(cond, u[0], a, a);
                run_branch(cond, u[0], 32'hffff_fff0, 32'h0000_0010); // sign flips order
                run_branch(cond, u[0], 32'h0000_0010, 32'hffff_fff0);
                run_branch(cond, u[0], $urandom(), $urandom());
            end
        end
        repeat (4) begin
            imm = 20'($urandom());
            f   = '0;
            f.rvi.op[exu_pkg::OP_JAL] = 1'b1;
            drive_op(SET_RVI, f, $urandom(), $urandom(), imm, 1'b1);
            check_result(pc - exu_pkg::PC_LAG + 32'd4, 1'b1);
            compare("jump_addr_o", jump_addr, pc - exu_pkg::PC_LAG + {{11{imm[19]}}, imm, 1'b0});
            a = $urandom();
            f = '0;
            f.rvi.op[exu_pkg::OP_JALR] = 1'b1;
            drive_op(SET_RVI, f, a, $urandom(), imm, 1'b1);
            check_result(pc - exu_pkg::PC_LAG + 32'd4, 1'b1);
            compare("jump_addr_o", jump_addr, (a + {{20{imm[11]}}, imm[11:0]}) & ~32'd1);
        end
    endtask

    task automatic run_mul(input logic uns1, input logic uns2, input logic high,
                           input logic [W-1:0] a, input logic [W-1:0] b);
        exu_pkg::exu_func_u f;
        logic [2*W-1:0]     a64;
        logic [2*W-1:0]     b64;
        logic [2*W-1:0]     prod;
        f = '0;
        f.rvm.op[exu_pkg::OP_MUL] = 1'b1;
        f.rvm.high       = high;
        f.rvm.unsign     = uns1 | uns2;
        f.rvm.op1_unsign = uns1;
        f.rvm.op2_unsign = uns2;
        a64  = uns1 ? {32'b0, a} : {{32{a[31]}}, a};
        b64  = uns2 ? {32'b0, b} : {{32{b[31]}}, b};
        prod = a64 * b64;
        drive_op(SET_RVM, f, a, b, '0, 1'b1);
        check_result(high ? prod[2*W-1:W] : prod[W-1:0], 1'b0);
    endtask

    task automatic test_mul();
        for (int signs = 0; signs < 4; signs++) begin
            for (int high = 0; high < 2; high++) begin
                repeat (3) begin
                    run_mul(signs[0], signs[1], high[0], $urandom(), $urandom());
                end
                run_mul(signs[0], signs[1], high[0], 32'h8000_0000, 32'hffff_ffff);
                run_mul(signs[0], signs[1], high[0], 32'hffff_ffff, 32'hffff_ffff);
            end
        end
    endtask

    task automatic run_divide(input logic is_rem, input logic uns, input logic [W-1:0] a,
                              input logic [W-1:0] b);
        exu_pkg::exu_func_u             f;
        logic [exu_pkg::REG_ADDR_W-1:0] waddr_exp;
        int                             cycles;
        f = '0;
        f.rvm.op[is_rem ? exu_pkg::OP_REM : exu_pkg::OP_DIV] = 1'b1;
        f.rvm.unsign     = uns;
        f.rvm.op1_unsign = uns;
        f.rvm.op2_unsign = uns;
        drive_op(SET_RVM, f, a, b, '0, 1'b0);
        waddr_exp = reg_waddr;
        compare("hold_flag_o", hold_flag, 1'b1);
        compare("result_vld_o", result_vld, 1'b0);
        next_cycle();
        reg_waddr = ~waddr_exp;     // only the captured address may come back
        #SAMPLE_DLY;
        cycles = 0;
        while (result_vld !== 1'b1) begin
            if (cycles == DIV_TIMEOUT) begin
                $display("Divide gave no result within %0d cycles", DIV_TIMEOUT);
                abort_run();
            end
            @(posedge clk);
            #(DRIVE_DLY + SAMPLE_DLY);
            cycles++;
        end
        compare("result_o", result, divide_ref(is_rem, uns, a, b));
        compare("reg_waddr_o", reg_waddr_out, waddr_exp);
        compare("reg_waddr_vld_o", reg_waddr_vld_out, 1'b1);
        compare("hold_flag_o", hold_flag, 1'b0);
    endtask

    task automatic test_div();
        logic [W-1:0] a;
        logic [W-1:0] b;
        repeat (6) begin
            a = $urandom();
            b = $urandom() >> ($urandom() % 32);    // spread the quotient sizes
            for (int k = 0; k < 4; k++) begin
                run_divide(k[0], k[1], a, b);
            end
        end
        for (int k = 0; k < 4; k++) begin
            run_divide(k[0], k[1], 32'hffff_ff85, 32'h0);
        end
        run_divide(1'b0, 1'b0, 32'h8000_0000, 32'hffff_ffff);
        run_divide(1'b1, 1'b0, 32'h8000_0000, 32'hffff_ffff);
        next_cycle();
        clear_inputs();
        #SAMPLE_DLY;
        compare("hold_flag_o", hold_flag, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h541a_0828));
        clear_inputs();
        test_reset();
        test_alu();
        test_branch();
        test_mul();
        test_div();
        $display("Regression passed");
        $finish;
    end

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic reset_o
);

    localparam int HALF_PERIOD  = 20;   // 40 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD;
            clk_o = ~clk_o;
        end
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        reset_o = 1'b0;     // same offset as the stimulus
    end

endmodule

/* exu.f */
common/exu_pkg.sv
hdl/operand_sel.sv
hdl/int_alu.sv
hdl/branch_unit.sv
muldiv/md_sign.sv
muldiv/mul_unit.sv
muldiv/div_seq.sv
hdl/exu.sv
dv/tb_clk_gen.sv
dv/exu_tb.sv

/* hdl/branch_unit.sv */
`timescale 1ns/10ps

module branch_unit (
    input  exu_pkg::exu_func_u          inst_func_i,
    input  logic [23:0]                 rvi_ops_i,
    input  logic [exu_pkg::DATA_W-1:0]  op1_i,
    input  logic [exu_pkg::DATA_W-1:0]  op2_i,
    input  logic [exu_pkg::DATA_W-1:0]  pc_i,
    input  logic [exu_pkg::IMM_W-1:0]   uimm_i,
    output logic                        jump_flag_o,
    output logic [exu_pkg::DATA_W-1:0]  jump_addr_o
);

    localparam int W = exu_pkg::DATA_W;

    logic [W-1:0] inst_addr;
    logic [W:0]   diff;
    logic         is_eq;
    logic         is_lt;
    logic         taken;
    logic         br_jump;
    logic [W-1:0] br_target;
    logic [W-1:0] jal_target;
    logic [W-1:0] jalr_target;

    assign inst_addr = pc_i - exu_pkg::PC_LAG;

    assign diff  = {!inst_func_i.rvi.unsign & op1_i[W-1], op1_i}
                 - {!inst_func_i.rvi.unsign & op2_i[W-1], op2_i};
    assign is_eq = (diff == '0);
    assign is_lt = diff[W]; // borrow out

    assign taken = inst_func_i.rvi.eq &  is_eq
                 | inst_func_i.rvi.ne & !is_eq
                 | inst_func_i.rvi.lt &  is_lt
                 | inst_func_i.rvi.ge & !is_lt;

    assign br_target   = inst_addr + {{19{uimm_i[11]}}, uimm_i[11:0], 1'b0};
    assign jal_target  = inst_addr + {{11{uimm_i[19]}}, uimm_i, 1'b0};
    assign jalr_target = (op1_i + {{20{uimm_i[11]}}, uimm_i[11:0]}) & ~32'd1;

    assign br_jump     = rvi_ops_i[exu_pkg::OP_B] & taken;
    assign jump_flag_o = br_jump | rvi_ops_i[exu_pkg::OP_JAL] | rvi_ops_i[exu_pkg::OP_JALR];

    assign jump_addr_o = {W{br_jump}}                    & br_target
                       | {W{rvi_ops_i[exu_pkg::OP_JAL]}}  & jal_target
                       | {W{rvi_ops_i[exu_pkg::OP_JALR]}} & jalr_target;

endmodule

/* hdl/exu.sv */
`timescale 1ns/10ps

module exu (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic [1:0]                          inst_set_i,
    input  exu_pkg::exu_func_u                  inst_func_i,
    input  logic [exu_pkg::DATA_W-1:0]          pc_i,
    input  logic [exu_pkg::DATA_W-1:0]          reg1_rdata_i,
    input  logic [exu_pkg::DATA_W-1:0]          reg2_rdata_i,
    input  logic [exu_pkg::IMM_W-1:0]           uimm_i,
    input  logic [exu_pkg::REG_ADDR_W-1:0]      reg_waddr_i,
    input  logic                                reg_waddr_vld_i,
    output logic                                hold_flag_o,
    output logic                                jump_flag_o,
    output logic [exu_pkg::DATA_W-1:0]          jump_addr_o,
    output logic [exu_pkg::REG_ADDR_W-1:0]      reg_waddr_o,
    output logic                                reg_waddr_vld_o,
    output logic [exu_pkg::DATA_W-1:0]          result_o,
    output logic                                result_vld_o
);

    logic [23:0]                        rvi_ops;
    logic [exu_pkg::DATA_W-1:0]         op1;
    logic [exu_pkg::DATA_W-1:0]         op2;
    logic [exu_pkg::DATA_W-1:0]         alu_result;
    logic                               alu_vld;
    logic                               op_mul;
    logic                               op_div;
    logic                               op_rem;
    logic                               mul_high;
    logic [exu_pkg::DATA_W-1:0]         mag1;
    logic [exu_pkg::DATA_W-1:0]         mag2;
    logic                               q_neg;
    logic                               r_neg;
    logic [exu_pkg::DATA_W-1:0]         mul_result;
    logic                               mul_vld;
    logic [exu_pkg::DATA_W-1:0]         div_result;
    logic                               div_vld;
    logic [exu_pkg::REG_ADDR_W-1:0]     div_waddr;

    operand_sel i_operand_sel (
        .inst_set_i     (inst_set_i),
        .inst_func_i    (inst_func_i),
        .reg1_rdata_i   (reg1_rdata_i),
        .reg2_rdata_i   (reg2_rdata_i),
        .uimm_i         (uimm_i),
        .rvi_ops_o      (rvi_ops),
        .op1_o          (op1),
        .op2_o          (op2)
    );

    int_alu i_int_alu (
        .rvi_ops_i      (rvi_ops),
        .unsigned_i     (inst_func_i.rvi.unsign),
        .op1_i          (op1),
        .op2_i          (op2),
        .pc_i           (pc_i),
        .uimm_i         (uimm_i),
        .result_o       (alu_result),
        .result_vld_o   (alu_vld)
    );

    branch_unit i_branch_unit (
        .inst_func_i    (inst_func_i),
        .rvi_ops_i      (rvi_ops),
        .op1_i          (op1),
        .op2_i          (op2),
        .pc_i           (pc_i),
        .uimm_i         (uimm_i),
        .jump_flag_o    (jump_flag_o),
        .jump_addr_o    (jump_addr_o)
    );

    md_sign i_md_sign (
        .inst_set_i     (inst_set_i),
        .inst_func_i    (inst_func_i),
        .reg1_rdata_i   (reg1_rdata_i),
        .reg2_rdata_i   (reg2_rdata_i),
        .mul_o          (op_mul),
        .div_o          (op_div),
        .rem_o          (op_rem),
        .high_o         (mul_high),
        .mag1_o         (mag1),
        .mag2_o         (mag2),
        .q_neg_o        (q_neg),
        .r_neg_o        (r_neg)
    );

    mul_unit i_mul_unit (
        .mul_i          (op_mul),
        .high_i         (mul_high),
        .mag1_i         (mag1),
        .mag2_i         (mag2),
        .neg_i          (q_neg),        // product sign follows quotient sign
        .result_o       (mul_result),
        .result_vld_o   (mul_vld)
    );

    div_seq i_div_seq (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .div_i          (op_div),
        .rem_i          (op_rem),
        .mag1_i         (mag1),
        .mag2_i         (mag2),
        .q_neg_i        (q_neg),
        .r_neg_i        (r_neg),
        .reg_waddr_i    (reg_waddr_i),
        .hold_o         (hold_flag_o),
        .result_o       (div_result),
        .result_vld_o   (div_vld),
        .reg_waddr_o    (div_waddr)
    );

    assign reg_waddr_o     = div_vld ? div_waddr : reg_waddr_i;
    assign reg_waddr_vld_o = div_vld | reg_waddr_vld_i;

    assign result_o = {exu_pkg::DATA_W{alu_vld}} & alu_result
                    | {exu_pkg::DATA_W{mul_vld}} & mul_result
                    | {exu_pkg::DATA_W{div_vld}} & div_result;

    assign result_vld_o = alu_vld | mul_vld | div_vld;

endmodule

/* hdl/int_alu.sv */
`timescale 1ns/10ps

module int_alu (
    input  logic [23:0]                 rvi_ops_i,
    input  logic                        unsigned_i,
    input  logic [exu_pkg::DATA_W-1:0]  op1_i,
    input  logic [exu_pkg::DATA_W-1:0]  op2_i,
    input  logic [exu_pkg::DATA_W-1:0]  pc_i,
    input  logic [exu_pkg::IMM_W-1:0]   uimm_i,
    output logic [exu_pkg::DATA_W-1:0]  result_o,
    output logic                        result_vld_o
);

    localparam int W = exu_pkg::DATA_W;

    logic [W-1:0] inst_addr;
    logic [W-1:0] res_add;
    logic [W-1:0] res_sub;
    logic [W-1:0] res_sll;
    logic [W-1:0] res_srl;
    logic [W-1:0] res_sra;
    logic [W-1:0] res_slt;
    logic [W-1:0] res_lui;
    logic [W-1:0] res_auipc;
    logic [W-1:0] res_link;
    logic [W:0]   slt_diff;
    logic         op1_ext;
    logic         op2_ext;

    assign inst_addr = pc_i - exu_pkg::PC_LAG;

    assign res_add = op1_i + op2_i;
    assign res_sub = op1_i - op2_i;
    assign res_sll = op1_i << op2_i[4:0];
    assign res_srl = op1_i >> op2_i[4:0];
    assign res_sra = res_srl | (~({W{1'b1}} >> op2_i[4:0]) & {W{op1_i[W-1]}}); // fill sign

    // extend to 33 bits so one subtract serves slt and sltu
    assign op1_ext  = !unsigned_i & op1_i[W-1];
    assign op2_ext  = !unsigned_i & op2_i[W-1];
    assign slt_diff = {op1_ext, op1_i} - {op2_ext, op2_i};
    assign res_slt  = {{(W-1){1'b0}}, slt_diff[W]};

    assign res_lui   = {uimm_i, 12'b0};
    assign res_auipc = inst_addr + res_lui;
    assign res_link  = inst_addr + 32'd4;

    always_comb begin
        result_o = {W{rvi_ops_i[exu_pkg::OP_ADD]}}   & res_add
                 | {W{rvi_ops_i[exu_pkg::OP_SUB]}}   & res_sub
                 | {W{rvi_ops_i[exu_pkg::OP_SLL]}}   & res_sll
                 | {W{rvi_ops_i[exu_pkg::OP_SRL]}}   & res_srl
                 | {W{rvi_ops_i[exu_pkg::OP_SRA]}}   & res_sra
                 | {W{rvi_ops_i[exu_pkg::OP_OR]}}    & (op1_i | op2_i)
                 | {W{rvi_ops_i[exu_pkg::OP_AND]}}   & (op1_i & op2_i)
                 | {W{rvi_ops_i[exu_pkg::OP_XOR]}}   & (op1_i ^ op2_i)
                 | {W{rvi_ops_i[exu_pkg::OP_SLT]}}   & res_slt
                 | {W{rvi_ops_i[exu_pkg::OP_LUI]}}   & res_lui
                 | {W{rvi_ops_i[exu_pkg::OP_AUIPC]}} & res_auipc
                 | {W{rvi_ops_i[exu_pkg::OP_JAL] | rvi_ops_i[exu_pkg::OP_JALR]}} & res_link;
    end

    // branches count as valid with a zero result
    assign result_vld_o = |{rvi_ops_i[exu_pkg::OP_ADD:exu_pkg::OP_SLT],
                            rvi_ops_i[exu_pkg::OP_B],
                            rvi_ops_i[exu_pkg::OP_JAL],
                            rvi_ops_i[exu_pkg::OP_JALR],
                            rvi_ops_i[exu_pkg::OP_AUIPC],
                            rvi_ops_i[exu_pkg::OP_LUI]};

endmodule

/* hdl/operand_sel.sv */
`timescale 1ns/10ps

module operand_sel (
    input  logic [1:0]                  inst_set_i,
    input  exu_pkg::exu_func_u          inst_func_i,
    input  logic [exu_pkg::DATA_W-1:0]  reg1_rdata_i,
    input  logic [exu_pkg::DATA_W-1:0]  reg2_rdata_i,
    input  logic [exu_pkg::IMM_W-1:0]   uimm_i,
    output logic [23:0]                 rvi_ops_o,
    output logic [exu_pkg::DATA_W-1:0]  op1_o,
    output logic [exu_pkg::DATA_W-1:0]  op2_o
);

    logic [exu_pkg::DATA_W-1:0] imm12_zext;
    logic [exu_pkg::DATA_W-1:0] imm12_sext;
    logic [exu_pkg::DATA_W-1:0] imm_sel;

    assign rvi_ops_o = {24{inst_set_i[exu_pkg::SET_RVI_BIT]}} & inst_func_i.rvi.op;

    assign imm12_zext = {20'b0, uimm_i[11:0]};
    assign imm12_sext = {{20{uimm_i[11]}}, uimm_i[11:0]};

    // sltiu still sign-extends, only the compare is unsigned
    always_comb begin
        if (rvi_ops_o[exu_pkg::OP_SLT] || !inst_func_i.rvi.unsign) begin
            imm_sel = imm12_sext;
        end else begin
            imm_sel = imm12_zext;
        end
    end

    assign op1_o = reg1_rdata_i;
    assign op2_o = inst_func_i.rvi.imm ? imm_sel : reg2_rdata_i;

endmodule

/* muldiv/div_seq.sv */
`timescale 1ns/10ps

module div_seq (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            div_i,
    input  logic                            rem_i,
    input  logic [exu_pkg::DATA_W-1:0]      mag1_i,
    input  logic [exu_pkg::DATA_W-1:0]      mag2_i,
    input  logic                            q_neg_i,
    input  logic                            r_neg_i,
    input  logic [exu_pkg::REG_ADDR_W-1:0]  reg_waddr_i,
    output logic                            hold_o,
    output logic [exu_pkg::DATA_W-1:0]      result_o,
    output logic                            result_vld_o,
    output logic [exu_pkg::REG_ADDR_W-1:0]  reg_waddr_o
);

    localparam int W     = exu_pkg::DATA_W;
    localparam int CNT_W = $clog2(exu_pkg::DATA_W);

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(W - 1);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ITER = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    logic [1:0]                     state_q;
    logic [CNT_W-1:0]               cnt_q;
    logic [W-1:0]                   rem_q;      // partial remainder
    logic [W-1:0]                   quot_q;     // dividend shifts out, quotient in
    logic [W-1:0]                   divisor_q;
    logic                           q_neg_q;
    logic                           r_neg_q;
    logic                           is_rem_q;
    logic                           div_zero_q;
    logic [exu_pkg::REG_ADDR_W-1:0] waddr_q;

    logic         start;
    logic [W:0]   trial;
    logic [W-1:0] quot_final;
    logic [W-1:0] rem_final;

    assign start = (state_q == ST_IDLE) & (div_i | rem_i);
    assign trial = {rem_q, quot_q[W-1]} - {1'b0, divisor_q};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_ITER;
                        cnt_q   <= '0;
                    end
                end
                ST_ITER: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_LAST) begin
                        state_q <= ST_DONE;
                    end
                end
                default: state_q <= ST_IDLE; // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            rem_q      <= '0;
            quot_q     <= mag1_i;
            divisor_q  <= mag2_i;
            q_neg_q    <= q_neg_i;
            r_neg_q    <= r_neg_i;
            is_rem_q   <= rem_i;
            div_zero_q <= (mag2_i == '0);
            waddr_q    <= reg_waddr_i;
        end else if (state_q == ST_ITER) begin
            if (trial[W]) begin     // restore
                rem_q  <= {rem_q[W-2:0], quot_q[W-1]};
                quot_q <= {quot_q[W-2:0], 1'b0};
            end else begin
                rem_q  <= trial[W-1:0];
                quot_q <= {quot_q[W-2:0], 1'b1};
            end
        end
    end

    // a zero divisor leaves the dividend as remainder on its own
    assign quot_final = div_zero_q ? {W{1'b1}} : (q_neg_q ? -quot_q : quot_q);
    assign rem_final  = r_neg_q ? -rem_q : rem_q;

    assign hold_o       = start | (state_q == ST_ITER);
    assign result_vld_o = (state_q == ST_DONE);
    assign result_o     = is_rem_q ? rem_final : quot_final;
    assign reg_waddr_o  = waddr_q;

endmodule

/* muldiv/md_sign.sv */
`timescale 1ns/10ps

module md_sign (
    input  logic [1:0]                  inst_set_i,
    input  exu_pkg::exu_func_u          inst_func_i,
    input  logic [exu_pkg::DATA_W-1:0]  reg1_rdata_i,
    input  logic [exu_pkg::DATA_W-1:0]  reg2_rdata_i,
    output logic                        mul_o,
    output logic                        div_o,
    output logic                        rem_o,
    output logic                        high_o,
    output logic [exu_pkg::DATA_W-1:0]  mag1_o,
    output logic [exu_pkg::DATA_W-1:0]  mag2_o,
    output logic                        q_neg_o,
    output logic                        r_neg_o
);

    logic rvm;
    logic neg1;
    logic neg2;

    assign rvm   = inst_set_i[exu_pkg::SET_RVM_BIT];
    assign mul_o = rvm & inst_func_i.rvm.op[exu_pkg::OP_MUL];
    assign div_o = rvm & inst_func_i.rvm.op[exu_pkg::OP_DIV];
    assign rem_o = rvm & inst_func_i.rvm.op[exu_pkg::OP_REM];

    assign high_o = inst_func_i.rvm.high;

    // per-operand unsigned only counts with the global unsigned flag
    assign neg1 = !(inst_func_i.rvm.unsign & inst_func_i.rvm.op1_unsign)
                & reg1_rdata_i[exu_pkg::DATA_W-1];
    assign neg2 = !(inst_func_i.rvm.unsign & inst_func_i.rvm.op2_unsign)
                & reg2_rdata_i[exu_pkg::DATA_W-1];

    assign mag1_o = neg1 ? -reg1_rdata_i : reg1_rdata_i;
    assign mag2_o = neg2 ? -reg2_rdata_i : reg2_rdata_i;

    assign q_neg_o = neg1 ^ neg2;
    assign r_neg_o = neg1;  // remainder follows dividend

endmodule

/* muldiv/mul_unit.sv */
`timescale 1ns/10ps

module mul_unit (
    input  logic                        mul_i,
    input  logic                        high_i,
    input  logic [exu_pkg::DATA_W-1:0]  mag1_i,
    input  logic [exu_pkg::DATA_W-1:0]  mag2_i,
    input  logic                        neg_i,
    output logic [exu_pkg::DATA_W-1:0]  result_o,
    output logic                        result_vld_o
);

    localparam int W = exu_pkg::DATA_W;

    logic [2*W-1:0] prod_mag;
    logic [2*W-1:0] prod;

    assign prod_mag = mag1_i * mag2_i;
    assign prod     = neg_i ? -prod_mag : prod_mag; // restore sign on full 64 bits

    assign result_o     = high_i ? prod[2*W-1:W] : prod[W-1:0];
    assign result_vld_o = mul_i;

endmodule
